//--- rtl/rename_cfg_pkg.sv
package rename_cfg_pkg;

    // ==================================================
    // machine width
    // ==================================================
    // rename lanes per cycle
    localparam int unsigned DISPATCH_WIDTH = 2;
    // retire lanes per cycle
    localparam int unsigned COMMIT_WIDTH   = 2;

    // ==================================================
    // register files
    // ==================================================
    localparam int unsigned ARCH_REGS = 32;
    localparam int unsigned PHYS_REGS = 64;
    // phys regs not pinned by the committed map at reset
    localparam int unsigned FREE_REGS = PHYS_REGS - ARCH_REGS;

    // index widths
    localparam int unsigned ARCH_IDX_W = $clog2(ARCH_REGS);
    localparam int unsigned PHYS_IDX_W = $clog2(PHYS_REGS);
    // holds 0 .. FREE_REGS inclusive
    localparam int unsigned COUNT_W    = $clog2(FREE_REGS + 1);
    // head / tail pointers of the free queue
    localparam int unsigned FREE_PTR_W = $clog2(FREE_REGS);

endpackage

//--- rtl/rename_types_pkg.sv
package rename_types_pkg;

    import rename_cfg_pkg::*;

    // ==================================================
    // register indices
    // ==================================================
    typedef logic [ARCH_IDX_W-1:0] arch_idx_t;
    typedef logic [PHYS_IDX_W-1:0] phys_idx_t;
    // free list occupancy, 0 .. FREE_REGS
    typedef logic [COUNT_W-1:0]    free_count_t;

    // instruction class, only alu and load write a dest
    typedef enum logic [2:0] {
        OP_ALU    = 3'd0,
        OP_LOAD   = 3'd1,
        OP_STORE  = 3'd2,
        OP_BRANCH = 3'd3,
        OP_NOP    = 3'd4
    } opcode_e;

    // ==================================================
    // lane payloads
    // ==================================================
    // front end -> rename, 19 bits
    typedef struct packed {
        logic      valid;
        opcode_e   opcode;
        arch_idx_t src1;
        arch_idx_t src2;
        arch_idx_t dest;
    } rename_req_t;

    // rename -> dispatch, 25 bits
    // pdest / old_pdest read 0 when the lane writes nothing
    typedef struct packed {
        logic      valid;
        phys_idx_t psrc1;
        phys_idx_t psrc2;
        phys_idx_t pdest;
        phys_idx_t old_pdest;
    } rename_rsp_t;

    // rob retire lane, 12 bits
    typedef struct packed {
        logic      valid;
        arch_idx_t dest;
        phys_idx_t pdest;
    } commit_t;

endpackage

//--- rtl/free_list.sv
module free_list (
    input  logic                                                 clock,
    input  logic                                                 reset,
    // dispatch side
    input  logic [rename_cfg_pkg::DISPATCH_WIDTH-1:0]            alloc_req_i,
    output rename_types_pkg::phys_idx_t [rename_cfg_pkg::DISPATCH_WIDTH-1:0] alloc_phys_o,
    output logic [rename_cfg_pkg::DISPATCH_WIDTH-1:0]            alloc_valid_o,
    // commit side
    input  logic [rename_cfg_pkg::COMMIT_WIDTH-1:0]              free_valid_i,
    input  rename_types_pkg::phys_idx_t [rename_cfg_pkg::COMMIT_WIDTH-1:0] free_phys_i,
    // status
    output logic                                                 full_o,
    output rename_types_pkg::free_count_t                        free_count_o
);

    import rename_cfg_pkg::*;
    import rename_types_pkg::*;

    // ==================================================
    // queue state
    // ==================================================
    phys_idx_t              free_fifo [FREE_REGS];
    logic [FREE_PTR_W-1:0]  head;
    // next slot to fill
    logic [FREE_PTR_W-1:0]  tail;
    free_count_t            count;
    free_count_t            next_count;

    // per-cycle sums are one bit wider than count
    logic [COUNT_W:0]       n_free;
    logic [COUNT_W:0]       n_alloc;
    logic [COUNT_W:0]       avail;
    // releases packed down to the low lanes
    phys_idx_t [COMMIT_WIDTH-1:0] rel_phys;
    // cleared by the first requesting lane that misses
    logic                   chain_ok;

    // wrap a pointer around the queue
    function automatic logic [FREE_PTR_W-1:0] ptr_add(
        input logic [FREE_PTR_W-1:0] ptr,
        input logic [COUNT_W:0]      n
    );
        logic [COUNT_W+1:0] sum;
        sum = ptr + n;
        return FREE_PTR_W'(sum % FREE_REGS);
    endfunction

    assign free_count_o = count;
    assign full_o       = (count < DISPATCH_WIDTH);

    // ==================================================
    // release side, counted first
    // ==================================================
    always_comb begin : release_pack
        n_free = '0;
        for (int j = 0; j < COMMIT_WIDTH; j++) begin
            rel_phys[j] = '0;
        end
        // skip idle commit lanes and keep lane order
        for (int j = 0; j < COMMIT_WIDTH; j++) begin
            if (free_valid_i[j]) begin
                rel_phys[n_free] = free_phys_i[j];
                n_free           = n_free + 1'b1;
            end
        end
    end

    // ==================================================
    // allocation side
    // ==================================================
    always_comb begin : alloc_grant
        // this cycle's frees are allocatable too
        avail    = {1'b0, count} + n_free;
        n_alloc  = '0;
        chain_ok = 1'b1;
        for (int i = 0; i < DISPATCH_WIDTH; i++) begin
            alloc_valid_o[i] = 1'b0;
            alloc_phys_o[i]  = '0;
            if (alloc_req_i[i]) begin
                if (chain_ok && (n_alloc < avail)) begin
                    alloc_valid_o[i] = 1'b1;
                    // queued entries before the release lanes
                    if (n_alloc < {1'b0, count}) begin
                        alloc_phys_o[i] = free_fifo[ptr_add(head, n_alloc)];
                    end else begin
                        alloc_phys_o[i] = rel_phys[n_alloc - {1'b0, count}];
                    end
                    n_alloc = n_alloc + 1'b1;
                end else begin
                    // later lanes must wait their turn
                    chain_ok = 1'b0;
                end
            end
        end
        next_count = free_count_t'(avail - n_alloc);
    end

    // ==================================================
    // queue update
    // ==================================================
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            head  <= '0;
            // queue starts full so tail wraps onto head
            tail  <= '0;
            count <= free_count_t'(FREE_REGS);
            for (int i = 0; i < FREE_REGS; i++) begin
                free_fifo[i] <= phys_idx_t'(ARCH_REGS + i);
            end
        end else begin
            head  <= ptr_add(head, n_alloc);
            tail  <= ptr_add(tail, n_free);
            count <= next_count;
            // bypassed frees are written too and head steps past them
            for (int k = 0; k < COMMIT_WIDTH; k++) begin
                if ((COUNT_W+1)'(k) < n_free) begin
                    free_fifo[ptr_add(tail, (COUNT_W+1)'(k))] <= rel_phys[k];
                end
            end
        end
    end

    // ==================================================
    // checks
    // ==================================================
    // a double free upstream would overfill the queue
    a_count_bound: assert property (@(posedge clock) disable iff (reset)
        count <= FREE_REGS);

    // p0 is the home of r0 and never cycles
    for (genvar j = 0; j < COMMIT_WIDTH; j++) begin : g_rel_chk
        a_no_free_p0: assert property (@(posedge clock) disable iff (reset)
            free_valid_i[j] |-> (free_phys_i[j] != '0));
    end

    // nor is p0 ever handed to a dest
    for (genvar i = 0; i < DISPATCH_WIDTH; i++) begin : g_grant_chk
        a_grant_nz: assert property (@(posedge clock) disable iff (reset)
            alloc_valid_o[i] |-> (alloc_phys_o[i] != '0));
    end

endmodule

//--- rtl/map_table.sv
module map_table (
    input  logic                                                   clock,
    input  logic                                                   reset,
    // current rename group
    input  rename_types_pkg::rename_req_t [rename_cfg_pkg::DISPATCH_WIDTH-1:0] req_i,
    // lanes that really take a new dest this cycle
    input  logic [rename_cfg_pkg::DISPATCH_WIDTH-1:0]              wr_en_i,
    input  rename_types_pkg::phys_idx_t [rename_cfg_pkg::DISPATCH_WIDTH-1:0] new_pdest_i,
    // lookup results, valid field left low
    output rename_types_pkg::rename_rsp_t [rename_cfg_pkg::DISPATCH_WIDTH-1:0] rsp_o
);

    import rename_cfg_pkg::*;
    import rename_types_pkg::*;

    // ==================================================
    // speculative map
    // ==================================================
    // arch -> newest phys, identity out of reset
    phys_idx_t map_q [ARCH_REGS];

    // ==================================================
    // lookup with in-group bypass
    // ==================================================
    always_comb begin : lookup
        for (int i = 0; i < DISPATCH_WIDTH; i++) begin
            rsp_o[i]           = '0;
            rsp_o[i].psrc1     = map_q[req_i[i].src1];
            rsp_o[i].psrc2     = map_q[req_i[i].src2];
            rsp_o[i].old_pdest = map_q[req_i[i].dest];
            rsp_o[i].pdest     = new_pdest_i[i];
            // older lanes of the same group override the array
            // walk upward so the youngest older writer wins
            for (int k = 0; k < i; k++) begin
                if (wr_en_i[k]) begin
                    if (req_i[k].dest == req_i[i].src1) begin
                        rsp_o[i].psrc1 = new_pdest_i[k];
                    end
                    if (req_i[k].dest == req_i[i].src2) begin
                        rsp_o[i].psrc2 = new_pdest_i[k];
                    end
                    // two writes to one reg, second frees the first's pdest
                    if (req_i[k].dest == req_i[i].dest) begin
                        rsp_o[i].old_pdest = new_pdest_i[k];
                    end
                end
            end
        end
    end

    // ==================================================
    // update
    // ==================================================
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            for (int a = 0; a < ARCH_REGS; a++) begin
                map_q[a] <= phys_idx_t'(a);
            end
        end else begin
            // lane order, later lane lands last
            for (int i = 0; i < DISPATCH_WIDTH; i++) begin
                if (wr_en_i[i]) begin
                    map_q[req_i[i].dest] <= new_pdest_i[i];
                end
            end
        end
    end

    // ==================================================
    // checks
    // ==================================================
    // r0 is never renamed, relies on the dest decode upstream
    a_r0_pinned: assert property (@(posedge clock) disable iff (reset)
        map_q[0] == '0);

endmodule

//--- rtl/commit_map.sv
module commit_map (
    input  logic                                                 clock,
    input  logic                                                 reset,
    // retiring writes, oldest in lane 0
    input  rename_types_pkg::commit_t [rename_cfg_pkg::COMMIT_WIDTH-1:0] commit_i,
    // regs released by those writes
    output logic [rename_cfg_pkg::COMMIT_WIDTH-1:0]              free_valid_o,
    output rename_types_pkg::phys_idx_t [rename_cfg_pkg::COMMIT_WIDTH-1:0] free_phys_o
);

    import rename_cfg_pkg::*;
    import rename_types_pkg::*;

    // ==================================================
    // architectural state
    // ==================================================
    // committed arch -> phys, identity out of reset
    phys_idx_t cmap_q [ARCH_REGS];
    // lanes that actually retire a write
    logic [COMMIT_WIDTH-1:0] cm_wr;

    // ==================================================
    // replaced mapping per lane
    // ==================================================
    always_comb begin : release_lookup
        for (int j = 0; j < COMMIT_WIDTH; j++) begin
            // r0 retirements carry nothing to free
            cm_wr[j]        = commit_i[j].valid && (commit_i[j].dest != '0);
            free_valid_o[j] = cm_wr[j];
            free_phys_o[j]  = cmap_q[commit_i[j].dest];
            // same reg retired twice, younger frees the older pdest
            for (int k = 0; k < j; k++) begin
                if (cm_wr[k] && (commit_i[k].dest == commit_i[j].dest)) begin
                    free_phys_o[j] = commit_i[k].pdest;
                end
            end
        end
    end

    // ==================================================
    // update
    // ==================================================
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            for (int a = 0; a < ARCH_REGS; a++) begin
                cmap_q[a] <= phys_idx_t'(a);
            end
        end else begin
            for (int j = 0; j < COMMIT_WIDTH; j++) begin
                if (cm_wr[j]) begin
                    cmap_q[commit_i[j].dest] <= commit_i[j].pdest;
                end
            end
        end
    end

    // ==================================================
    // checks
    // ==================================================
    // rob must hand back the pdest rename gave, which is never p0
    for (genvar j = 0; j < COMMIT_WIDTH; j++) begin : g_cm_chk
        a_pdest_nz: assert property (@(posedge clock) disable iff (reset)
            (commit_i[j].valid && (commit_i[j].dest != '0))
                |-> (commit_i[j].pdest != '0));
    end

endmodule

//--- rtl/rename_unit.sv
module rename_unit (
    input  logic                                                 clock,
    input  logic                                                 reset,
    input  rename_types_pkg::rename_req_t [rename_cfg_pkg::DISPATCH_WIDTH-1:0] req_i,
    output rename_types_pkg::rename_rsp_t [rename_cfg_pkg::DISPATCH_WIDTH-1:0] rsp_o,
    input  rename_types_pkg::commit_t [rename_cfg_pkg::COMMIT_WIDTH-1:0] commit_i,
    output rename_types_pkg::free_count_t                        free_count_o,
    output logic                                                 full_o
);

    import rename_cfg_pkg::*;
    import rename_types_pkg::*;

    logic [DISPATCH_WIDTH-1:0]   need_dest;
    logic [DISPATCH_WIDTH-1:0]   alloc_valid;
    logic [DISPATCH_WIDTH-1:0]   lane_ok;
    logic [DISPATCH_WIDTH-1:0]   wr_en;
    phys_idx_t [DISPATCH_WIDTH-1:0]   alloc_phys;
    rename_rsp_t [DISPATCH_WIDTH-1:0] map_rsp;
    logic [COMMIT_WIDTH-1:0]     rel_valid;
    phys_idx_t [COMMIT_WIDTH-1:0] rel_phys;
    // drops at the first lane that fails
    logic                        ok_so_far;

    function automatic logic writes_dest(input opcode_e op);
        case (op)
            OP_ALU, OP_LOAD: return 1'b1;
            default:         return 1'b0;
        endcase
    endfunction

    // ==================================================
    // lane decode and in-order success chain
    // ==================================================
    always_comb begin : dest_decode
        for (int i = 0; i < DISPATCH_WIDTH; i++) begin
            // r0 dests take no new reg
            need_dest[i] = req_i[i].valid && writes_dest(req_i[i].opcode)
                           && (req_i[i].dest != '0);
        end
    end

    always_comb begin : lane_chain
        ok_so_far = 1'b1;
        for (int i = 0; i < DISPATCH_WIDTH; i++) begin
            lane_ok[i] = 1'b0;
            // idle lanes do not break the chain
            if (req_i[i].valid) begin
                lane_ok[i] = ok_so_far && (!need_dest[i] || alloc_valid[i]);
                ok_so_far  = lane_ok[i];
            end
        end
        wr_en = lane_ok & need_dest;
    end

    always_comb begin : rsp_build
        for (int i = 0; i < DISPATCH_WIDTH; i++) begin
            rsp_o[i]       = map_rsp[i];
            rsp_o[i].valid = lane_ok[i];
            if (!wr_en[i]) begin
                rsp_o[i].pdest     = '0;
                rsp_o[i].old_pdest = '0;
            end
        end
    end

    // ==================================================
    // blocks
    // ==================================================
    free_list u_free_list (
        .clock         (clock),
        .reset         (reset),
        .alloc_req_i   (need_dest),
        .alloc_phys_o  (alloc_phys),
        .alloc_valid_o (alloc_valid),
        .free_valid_i  (rel_valid),
        .free_phys_i   (rel_phys),
        .full_o        (full_o),
        .free_count_o  (free_count_o)
    );

    map_table u_map_table (
        .clock       (clock),
        .reset       (reset),
        .req_i       (req_i),
        .wr_en_i     (wr_en),
        .new_pdest_i (alloc_phys),
        .rsp_o       (map_rsp)
    );

    commit_map u_commit_map (
        .clock        (clock),
        .reset        (reset),
        .commit_i     (commit_i),
        .free_valid_o (rel_valid),
        .free_phys_o  (rel_phys)
    );

    // ==================================================
    // checks
    // ==================================================
    // free list plus commit bypass never hand out one reg twice
    a_distinct_pdest: assert property (@(posedge clock) disable iff (reset)
        (wr_en[0] && wr_en[1]) |-> (alloc_phys[0] != alloc_phys[1]));

endmodule

//--- dv/rename_unit_tb.sv
module rename_unit_tb;

    timeunit 1ns;
    timeprecision 1ps;

    import rename_cfg_pkg::*;
    import rename_types_pkg::*;

    localparam int CLK_PERIOD      = 20;
    localparam int RESET_CYCLES    = 3;
    localparam int DIRECTED_CYCLES = 100;
    localparam int RANDOM_CYCLES   = 300;
    // all stimulus cycles plus some slack
    localparam int WATCHDOG_NS =
        (RESET_CYCLES + DIRECTED_CYCLES + RANDOM_CYCLES) * CLK_PERIOD + 2000;

    logic clock = 1'b0;
    logic reset = 1'b1;
    rename_req_t [DISPATCH_WIDTH-1:0] req_i = '0;
    rename_rsp_t [DISPATCH_WIDTH-1:0] rsp_o;
    commit_t [COMMIT_WIDTH-1:0]       commit_i = '0;
    free_count_t                      free_count_o;
    logic                             full_o;

    // expected values driven alongside the inputs
    rename_rsp_t [DISPATCH_WIDTH-1:0] exp_rsp = '0;
    free_count_t                      exp_count = '0;
    logic                             exp_full = 1'b0;
    logic                             chk_en = 1'b0;
    int errors = 0;
    int err_mark = 0;
    int tests = 0;

    // ==================================================
    // reference model
    // ==================================================
    int        fq [$];
    phys_idx_t smap [ARCH_REGS];
    phys_idx_t cmap [ARCH_REGS];
    // renamed writes waiting to retire in age order
    commit_t   pend [$];

    rename_unit dut_i (
        .clock        (clock),
        .reset        (reset),
        .req_i        (req_i),
        .rsp_o        (rsp_o),
        .commit_i     (commit_i),
        .free_count_o (free_count_o),
        .full_o       (full_o)
    );

    always #(CLK_PERIOD / 2) clock = ~clock;

    // ==================================================
    // checks against the model
    // ==================================================
    a_rsp: assert property (@(posedge clock) disable iff (reset) chk_en |-> (rsp_o == exp_rsp))
    else begin
        errors++;
        $display("Error: rsp_o = %h, expected %h", $sampled(rsp_o), $sampled(exp_rsp));
    end

    a_count: assert property (@(posedge clock) disable iff (reset)
        chk_en |-> (free_count_o == exp_count))
    else begin
        errors++;
        $display("Error: free_count_o = %h, expected %h",
                 $sampled(free_count_o), $sampled(exp_count));
    end

    a_full: assert property (@(posedge clock) disable iff (reset) chk_en |-> (full_o == exp_full))
    else begin
        errors++;
        $display("Error: full_o = %h, expected %h", $sampled(full_o), $sampled(exp_full));
    end

    function automatic rename_req_t mk_req(input logic v, input opcode_e op,
                                           input int s1, input int s2, input int d);
        rename_req_t r;
        r.valid  = v;
        r.opcode = op;
        r.src1   = arch_idx_t'(s1);
        r.src2   = arch_idx_t'(s2);
        r.dest   = arch_idx_t'(d);
        return r;
    endfunction

    function automatic rename_req_t rand_req();
        // mostly valid lanes with any opcode and any reg incl r0
        return mk_req($urandom_range(0, 7) != 0, opcode_e'($urandom_range(0, 4)),
                      $urandom_range(0, 31), $urandom_range(0, 31), $urandom_range(0, 31));
    endfunction

    function automatic rename_req_t rand_alu();
        return mk_req(1'b1, OP_ALU, $urandom_range(0, 31), $urandom_range(0, 31),
                      $urandom_range(1, 31));
    endfunction

    // inputs and expectations of one cycle land together on the edge
    task automatic run_cycle(input rename_req_t [DISPATCH_WIDTH-1:0] rq,
                             input commit_t [COMMIT_WIDTH-1:0] cm);
        rename_rsp_t [DISPATCH_WIDTH-1:0] e;
        logic ok;
        logic need;
        int   cnt_before;
        @(posedge clock);
        cnt_before = fq.size();
        // releases go to the tail before any grant
        for (int j = 0; j < COMMIT_WIDTH; j++) begin
            if (cm[j].valid && (cm[j].dest != 0)) begin
                fq.push_back(int'(cmap[cm[j].dest]));
                cmap[cm[j].dest] = cm[j].pdest;
            end
        end
        ok = 1'b1;
        for (int i = 0; i < DISPATCH_WIDTH; i++) begin
            e[i]       = '0;
            // smap already holds older lanes of this group
            e[i].psrc1 = smap[rq[i].src1];
            e[i].psrc2 = smap[rq[i].src2];
            need = rq[i].valid && (rq[i].opcode == OP_ALU || rq[i].opcode == OP_LOAD)
                   && (rq[i].dest != 0);
            if (rq[i].valid) begin
                e[i].valid = ok && (!need || fq.size() > 0);
                ok = e[i].valid;
                if (e[i].valid && need) begin
                    e[i].pdest       = phys_idx_t'(fq.pop_front());
                    e[i].old_pdest   = smap[rq[i].dest];
                    smap[rq[i].dest] = e[i].pdest;
                    pend.push_back({1'b1, rq[i].dest, e[i].pdest});
                end
            end
        end
        req_i     <= rq;
        commit_i  <= cm;
        exp_rsp   <= e;
        exp_count <= free_count_t'(cnt_before);
        exp_full  <= (cnt_before < DISPATCH_WIDTH);
        chk_en    <= 1'b1;
    endtask

    // retire the oldest n writes while renaming two lanes
    task automatic step(input rename_req_t r0, input rename_req_t r1, input int n_commit);
        rename_req_t [DISPATCH_WIDTH-1:0] rq;
        commit_t [COMMIT_WIDTH-1:0]       cm;
        rq[0] = r0;
        rq[1] = r1;
        cm    = '0;
        for (int j = 0; j < n_commit && j < COMMIT_WIDTH && pend.size() > 0; j++) begin
            cm[j] = pend.pop_front();
        end
        run_cycle(rq, cm);
    endtask

    task automatic finish_test(input string name);
        step('0, '0, 0);
        // last active cycle is checked by now
        @(negedge clock);
        tests++;
        if (errors == err_mark) begin
            $display("test %0d %s: ok", tests, name);
        end else begin
            $display("test %0d %s: %0d mismatches", tests, name, errors - err_mark);
        end
        err_mark = errors;
    endtask

    // ==================================================
    // stimulus
    // ==================================================
    initial begin : watchdog
        #(WATCHDOG_NS);
        $display("watchdog expired, the run did not reach its end");
        $display("TESTBENCH FAILED");
        $finish;
    end

    initial begin : main
        int n_cm [6];
        void'($urandom(32'h9b3b_ac86));
        // the fifth entry retires both r9 writes in one cycle
        n_cm = '{1, 2, 2, 2, 2, 1};
        for (int a = 0; a < ARCH_REGS; a++) begin
            smap[a] = phys_idx_t'(a);
            cmap[a] = phys_idx_t'(a);
        end
        for (int p = ARCH_REGS; p < PHYS_REGS; p++) begin
            fq.push_back(p);
        end
        repeat (RESET_CYCLES) @(posedge clock);
        reset <= 1'b0;

        // reset state and then r1..r8 renamed in pairs
        step('0, '0, 0);
        for (int k = 0; k < 4; k++) begin
            step(mk_req(1'b1, OP_ALU, 0, 0, 2 * k + 1), mk_req(1'b1, OP_ALU, 0, 0, 2 * k + 2), 0);
        end
        finish_test("reset_and_alloc");

        // newest mapping and in-group bypass of src and old_pdest
        step(mk_req(1'b1, OP_ALU, 3, 5, 9), mk_req(1'b1, OP_LOAD, 9, 2, 9), 0);
        step(mk_req(1'b1, OP_ALU, 9, 8, 11), mk_req(1'b1, OP_ALU, 11, 11, 12), 0);
        finish_test("bypass");

        // no dest means nothing allocated
        step(mk_req(1'b1, OP_STORE, 4, 6, 7), mk_req(1'b1, OP_BRANCH, 1, 2, 3), 0);
        step(mk_req(1'b1, OP_NOP, 5, 5, 5), mk_req(1'b1, OP_ALU, 5, 6, 0), 0);
        step(mk_req(1'b1, OP_LOAD, 7, 0, 0), '0, 0);
        finish_test("no_dest");

        // drain the list and keep asking
        repeat (12) step(rand_alu(), rand_alu(), 0);
        step(rand_alu(), mk_req(1'b1, OP_NOP, 1, 2, 3), 0);
        step(mk_req(1'b1, OP_NOP, 1, 2, 3), rand_alu(), 0);
        finish_test("exhaust");

        // frees bypass straight to rename while r9 retires twice at once
        step(mk_req(1'b1, OP_ALU, 1, 2, 10), '0, 1);
        foreach (n_cm[c]) begin
            step(rand_alu(), rand_alu(), n_cm[c]);
        end
        finish_test("release_first");

        repeat (RANDOM_CYCLES) step(rand_req(), rand_req(), $urandom_range(0, 2));
        finish_test("random");

        $display("tests run %0d, mismatches %0d", tests, errors);
        if (errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

//--- rename_unit.f
rtl/rename_cfg_pkg.sv
rtl/rename_types_pkg.sv
rtl/free_list.sv
rtl/map_table.sv
rtl/commit_map.sv
rtl/rename_unit.sv
dv/rename_unit_tb.sv
